//--- hdl/scan_config.svh
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// limit on each timed phase, counted from phase entry
`define SCAN_TIMEOUT_CYCLES 64

// shutter settle time after it reports open
`define SCAN_SETTLE_CYCLES 8

// wait between finish resends
`define SCAN_RESEND_CYCLES 32

// resends after the first finish pulse
`define SCAN_RESEND_LIMIT 2

`endif

//--- hdl/scan_pkg.sv
package scan_pkg;

    // sequencer states, also reported on state_o
    typedef enum logic [3:0] {
        st_idle          = 4'd0,
        st_shutter_wait  = 4'd1,
        st_open_shutter  = 4'd2,
        st_fbc_close     = 4'd3,
        st_scan          = 4'd4,
        st_fbc_open      = 4'd5,
        st_close_shutter = 4'd6,
        st_error         = 4'd7,
        st_finish        = 4'd8
    } scan_state_e;

    // error codes as seen by the host
    typedef enum logic [3:0] {
        err_none                  = 4'd0,
        err_open_shutter_timeout  = 4'd1,
        err_fbc_close_timeout     = 4'd2,
        err_close_shutter_timeout = 4'd3,
        err_spindle_early         = 4'd4,
        err_fbc_ratio             = 4'd5,
        err_no_start_trigger      = 4'd6,
        err_fbc_oscillation       = 4'd7
    } scan_error_e;

    typedef struct packed {
        logic [31:0] shutter_pos;
        logic [31:0] start_pos;
        logic [31:0] end_pos;
        logic [31:0] plc_pos;
    } encode_thresholds_t;

    // start_reached is the raw compare, the others are registered
    typedef struct packed {
        logic shutter_reached;
        logic start_reached;
        logic start_rise;
        logic end_reached;
        logic plc_reached;
    } crossing_flags_t;

    typedef struct packed {
        logic shutter_closed;
        logic fbc_locked;
        logic fbc_ratio_err;
        logic fbc_osc_err;
    } plant_status_t;

    // shutter_set: 1 closes, 0 opens; shutter_en strobes it in
    typedef struct packed {
        logic shutter_set;
        logic shutter_en;
        logic fbc_close_loop;
        logic fbc_open_loop;
    } actuator_cmd_t;

endpackage

//--- hdl/encoder_crossing.sv
`timescale 1ns/1ns

module encoder_crossing (
    input  logic                         clk_i,
    input  logic                         scan_soft_reset_i,
    input  logic [31:0]                  encode_i,
    input  scan_pkg::encode_thresholds_t thresholds_i,
    output scan_pkg::crossing_flags_t    flags_o
);

    logic shutter_ge;
    logic start_ge;
    logic end_ge;
    logic plc_ge;

    logic shutter_q;
    logic start_q;
    logic start_q_d;
    logic end_q;
    logic plc_q;

    // encoder only moves upward during a scan, so >= marks the crossing
    assign shutter_ge = encode_i >= thresholds_i.shutter_pos;
    assign start_ge   = encode_i >= thresholds_i.start_pos;
    assign end_ge     = encode_i >= thresholds_i.end_pos;
    assign plc_ge     = encode_i >= thresholds_i.plc_pos;

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            shutter_q <= 1'b0;
            start_q   <= 1'b0;
            start_q_d <= 1'b0;
            end_q     <= 1'b0;
            plc_q     <= 1'b0;
        end else begin
            shutter_q <= shutter_ge;
            start_q   <= start_ge;
            start_q_d <= start_q;
            end_q     <= end_ge;
            plc_q     <= plc_ge;
        end
    end

    assign flags_o.shutter_reached = shutter_q;
    // early spindle check wants the compare without delay
    assign flags_o.start_reached   = start_ge;
    assign flags_o.start_rise      = start_q & ~start_q_d;
    assign flags_o.end_reached     = end_q;
    assign flags_o.plc_reached     = plc_q;

endmodule

//--- hdl/phase_timer.sv
`timescale 1ns/1ns
`include "scan_config.svh"

module phase_timer (
    input  logic clk_i,
    input  logic scan_soft_reset_i,
    input  logic phase_restart_i,
    input  logic timeout_run_i,
    input  logic settle_run_i,
    output logic timeout_o,
    output logic settle_done_o
);

    localparam int TIMEOUT_CYCLES = `SCAN_TIMEOUT_CYCLES;
    localparam int SETTLE_CYCLES  = `SCAN_SETTLE_CYCLES;
    localparam int TIMEOUT_W      = $clog2(TIMEOUT_CYCLES + 1);
    localparam int SETTLE_W       = $clog2(SETTLE_CYCLES + 1);

    logic [TIMEOUT_W-1:0] timeout_cnt;
    logic [SETTLE_W-1:0]  settle_cnt;

    // phase timeout, saturates at the limit
    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i || phase_restart_i) begin
            timeout_cnt <= '0;
        end else if (timeout_run_i && (timeout_cnt != TIMEOUT_W'(TIMEOUT_CYCLES))) begin
            timeout_cnt <= timeout_cnt + 1'b1;
        end
    end

    // settle time, restarts whenever the run condition drops
    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i || !settle_run_i) begin
            settle_cnt <= '0;
        end else if (settle_cnt != SETTLE_W'(SETTLE_CYCLES)) begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    assign timeout_o     = timeout_cnt == TIMEOUT_W'(TIMEOUT_CYCLES);
    assign settle_done_o = settle_cnt == SETTLE_W'(SETTLE_CYCLES);

endmodule

//--- hdl/scan_sequencer.sv
`timescale 1ns/1ns

module scan_sequencer (
    input  logic                     clk_i,
    input  logic                     scan_soft_reset_i,
    input  logic                     scan_start_cmd_i,
    input  scan_pkg::crossing_flags_t flags_i,
    input  scan_pkg::plant_status_t  status_i,
    input  logic                     fbc_switch_i,
    input  logic                     plc_enable_i,
    input  logic                     timeout_i,
    input  logic                     settle_done_i,
    output logic                     phase_restart_o,
    output logic                     timeout_run_o,
    output logic                     settle_run_o,
    output scan_pkg::actuator_cmd_t  cmd_o,
    output logic                     scan_active_o,
    output logic                     plc_acc_o,
    output logic                     error_pulse_o,
    output scan_pkg::scan_error_e    error_code_o,
    output logic                     finish_req_o,
    output scan_pkg::scan_state_e    state_o
);

    import scan_pkg::*;

    scan_state_e   state_q;
    scan_state_e   state_d;
    scan_error_e   err_d;
    scan_error_e   error_code_q;
    actuator_cmd_t cmd_q;

    logic start_latched;
    logic fbc_used;
    logic scan_active_q;
    logic plc_acc_q;
    logic error_pulse_q;
    logic entering_error;
    logic entering_close;

    //////////////////////////////////////////////////
    // next state and error cause

    always_comb begin
        state_d = state_q;
        err_d   = err_none;
        case (state_q)
            st_idle: begin
                if (start_latched) begin
                    state_d = st_shutter_wait;
                end
            end
            st_shutter_wait: begin
                if (flags_i.shutter_reached) begin
                    state_d = st_open_shutter;
                end else if (flags_i.start_reached) begin
                    state_d = st_error;
                    err_d   = err_spindle_early;
                end
            end
            st_open_shutter: begin
                if (!status_i.shutter_closed && settle_done_i) begin
                    state_d = fbc_switch_i ? st_fbc_close : st_scan;
                end else if (flags_i.start_reached) begin
                    state_d = st_error;
                    err_d   = err_spindle_early;
                end else if (timeout_i) begin
                    state_d = st_error;
                    err_d   = err_open_shutter_timeout;
                end
            end
            st_fbc_close: begin
                if (status_i.fbc_locked) begin
                    state_d = st_scan;
                end else if (flags_i.start_reached) begin
                    state_d = st_error;
                    err_d   = err_spindle_early;
                end else if (timeout_i) begin
                    state_d = st_error;
                    err_d   = err_fbc_close_timeout;
                end
            end
            st_scan: begin
                if (flags_i.end_reached && scan_active_q) begin
                    state_d = fbc_used ? st_fbc_open : st_close_shutter;
                end else if (status_i.fbc_osc_err) begin
                    state_d = st_error;
                    err_d   = err_fbc_oscillation;
                end else if (flags_i.end_reached) begin
                    state_d = st_error;
                    err_d   = err_no_start_trigger;
                end else if (status_i.fbc_ratio_err) begin
                    state_d = st_error;
                    err_d   = err_fbc_ratio;
                end
            end
            st_fbc_open: begin
                if (!status_i.fbc_locked) begin
                    state_d = st_close_shutter;
                end else if (timeout_i) begin
                    // loop would not release, reported with the fbc loop code
                    state_d = st_error;
                    err_d   = err_fbc_close_timeout;
                end
            end
            st_close_shutter: begin
                if (status_i.shutter_closed) begin
                    state_d = st_finish;
                end else if (timeout_i) begin
                    state_d = st_error;
                    err_d   = err_close_shutter_timeout;
                end
            end
            st_error: begin
                state_d = st_error;
            end
            st_finish: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    assign entering_error = (state_q != st_error) && (state_d == st_error);
    assign entering_close = (state_q != st_close_shutter) && (state_d == st_close_shutter);

    //////////////////////////////////////////////////
    // state and registered commands

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            state_q       <= st_idle;
            start_latched <= 1'b0;
            fbc_used      <= 1'b0;
            cmd_q         <= '0;
            scan_active_q <= 1'b0;
            plc_acc_q     <= 1'b0;
            error_pulse_q <= 1'b0;
            error_code_q  <= err_none;
        end else begin
            state_q <= state_d;

            // a command during a running scan just stays latched
            if (scan_start_cmd_i) begin
                start_latched <= 1'b1;
            end else if (state_q == st_finish) begin
                start_latched <= 1'b0;
            end

            if (state_q == st_idle) begin
                fbc_used <= 1'b0;
            end else if (cmd_q.fbc_close_loop) begin
                fbc_used <= 1'b1;
            end

            // shutter strobes, set level holds between them
            if ((state_q == st_shutter_wait) && (state_d == st_open_shutter)) begin
                cmd_q.shutter_set <= 1'b0;
                cmd_q.shutter_en  <= 1'b1;
            end else if (entering_close || entering_error) begin
                cmd_q.shutter_set <= 1'b1;
                cmd_q.shutter_en  <= 1'b1;
            end else begin
                cmd_q.shutter_en <= 1'b0;
            end
            cmd_q.fbc_close_loop <= (state_q == st_open_shutter) && (state_d == st_fbc_close);
            cmd_q.fbc_open_loop  <= (state_q == st_scan) && (state_d == st_fbc_open);

            // active from the start crossing until scan is left
            if ((state_q == st_scan) && (state_d != st_scan)) begin
                scan_active_q <= 1'b0;
            end else if ((state_q == st_scan) && flags_i.start_rise) begin
                scan_active_q <= 1'b1;
            end

            plc_acc_q     <= (state_q == st_scan) && flags_i.plc_reached && plc_enable_i;
            error_pulse_q <= entering_error;
            if (entering_error) begin
                error_code_q <= err_d;
            end
        end
    end

    // timer control for the phase_timer block
    assign phase_restart_o = state_q != state_d;
    assign timeout_run_o   = state_q inside {st_open_shutter, st_fbc_close,
                                             st_fbc_open, st_close_shutter};
    assign settle_run_o    = (state_q == st_open_shutter) && !status_i.shutter_closed;

    assign cmd_o         = cmd_q;
    assign scan_active_o = scan_active_q;
    assign plc_acc_o     = plc_acc_q;
    assign error_pulse_o = error_pulse_q;
    assign error_code_o  = error_code_q;
    // finish lasts one cycle, so this is a single pulse
    assign finish_req_o  = state_q == st_finish;
    assign state_o       = state_q;

endmodule

//--- hdl/finish_notifier.sv
`timescale 1ns/1ns
`include "scan_config.svh"

module finish_notifier (
    input  logic clk_i,
    input  logic scan_soft_reset_i,
    input  logic finish_req_i,
    input  logic finish_ack_i,
    output logic finish_o
);

    localparam int RESEND_CYCLES = `SCAN_RESEND_CYCLES;
    localparam int RESEND_LIMIT  = `SCAN_RESEND_LIMIT;
    localparam int INTERVAL_W    = $clog2(RESEND_CYCLES + 1);
    localparam int RESENDS_W     = $clog2(RESEND_LIMIT + 1);

    logic                  waiting;
    logic [INTERVAL_W-1:0] interval_cnt;
    logic [RESENDS_W-1:0]  resend_cnt;
    logic                  finish_q;

    always_ff @(posedge clk_i) begin
        if (scan_soft_reset_i) begin
            waiting      <= 1'b0;
            interval_cnt <= '0;
            resend_cnt   <= '0;
            finish_q     <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (finish_req_i) begin
                // first report
                finish_q     <= 1'b1;
                waiting      <= 1'b1;
                interval_cnt <= '0;
                resend_cnt   <= '0;
            end else if (waiting) begin
                if (finish_ack_i) begin
                    waiting <= 1'b0;
                end else if (interval_cnt == INTERVAL_W'(RESEND_CYCLES)) begin
                    // no ack within the interval, send again
                    finish_q     <= 1'b1;
                    interval_cnt <= '0;
                    resend_cnt   <= resend_cnt + 1'b1;
                    if (resend_cnt == RESENDS_W'(RESEND_LIMIT - 1)) begin
                        waiting <= 1'b0;
                    end
                end else begin
                    interval_cnt <= interval_cnt + 1'b1;
                end
            end
        end
    end

    assign finish_o = finish_q;

endmodule

//--- hdl/scan_ctrl_top.sv
`timescale 1ns/1ns

module scan_ctrl_top (
    input  logic                         clk_i,
    input  logic                         scan_soft_reset_i,
    input  logic                         scan_start_cmd_i,
    input  logic [31:0]                  encode_i,
    input  scan_pkg::encode_thresholds_t thresholds_i,
    input  scan_pkg::plant_status_t      status_i,
    input  logic                         fbc_switch_i,
    input  logic                         plc_enable_i,
    input  logic                         finish_ack_i,
    output logic                         shutter_set_o,
    output logic                         shutter_en_o,
    output logic                         fbc_close_loop_o,
    output logic                         fbc_open_loop_o,
    output logic                         scan_active_o,
    output logic                         plc_acc_o,
    output logic                         error_o,
    output scan_pkg::scan_error_e        error_code_o,
    output logic                         finish_o,
    output scan_pkg::scan_state_e        state_o
);

    import scan_pkg::*;

    crossing_flags_t flags;
    actuator_cmd_t   cmd;
    logic            phase_restart;
    logic            timeout_run;
    logic            settle_run;
    logic            timeout;
    logic            settle_done;
    logic            finish_req;

    encoder_crossing i_encoder_crossing (
        .clk_i             (clk_i),
        .scan_soft_reset_i (scan_soft_reset_i),
        .encode_i          (encode_i),
        .thresholds_i      (thresholds_i),
        .flags_o           (flags)
    );

    phase_timer i_phase_timer (
        .clk_i             (clk_i),
        .scan_soft_reset_i (scan_soft_reset_i),
        .phase_restart_i   (phase_restart),
        .timeout_run_i     (timeout_run),
        .settle_run_i      (settle_run),
        .timeout_o         (timeout),
        .settle_done_o     (settle_done)
    );

    scan_sequencer i_scan_sequencer (
        .clk_i             (clk_i),
        .scan_soft_reset_i (scan_soft_reset_i),
        .scan_start_cmd_i  (scan_start_cmd_i),
        .flags_i           (flags),
        .status_i          (status_i),
        .fbc_switch_i      (fbc_switch_i),
        .plc_enable_i      (plc_enable_i),
        .timeout_i         (timeout),
        .settle_done_i     (settle_done),
        .phase_restart_o   (phase_restart),
        .timeout_run_o     (timeout_run),
        .settle_run_o      (settle_run),
        .cmd_o             (cmd),
        .scan_active_o     (scan_active_o),
        .plc_acc_o         (plc_acc_o),
        .error_pulse_o     (error_o),
        .error_code_o      (error_code_o),
        .finish_req_o      (finish_req),
        .state_o           (state_o)
    );

    finish_notifier i_finish_notifier (
        .clk_i             (clk_i),
        .scan_soft_reset_i (scan_soft_reset_i),
        .finish_req_i      (finish_req),
        .finish_ack_i      (finish_ack_i),
        .finish_o          (finish_o)
    );

    // actuator command fields out to pins
    assign shutter_set_o    = cmd.shutter_set;
    assign shutter_en_o     = cmd.shutter_en;
    assign fbc_close_loop_o = cmd.fbc_close_loop;
    assign fbc_open_loop_o  = cmd.fbc_open_loop;

endmodule

//--- verif/scan_ctrl_properties.sv
`timescale 1ns/1ns

module scan_ctrl_properties (
    input logic                  clk_i,
    input logic                  scan_soft_reset_i,
    input logic                  plc_enable_i,
    input logic                  shutter_set_i,
    input logic                  shutter_en_i,
    input logic                  fbc_close_loop_i,
    input logic                  fbc_open_loop_i,
    input logic                  scan_active_i,
    input logic                  plc_acc_i,
    input logic                  error_i,
    input scan_pkg::scan_error_e error_code_i,
    input logic                  finish_i,
    input scan_pkg::scan_state_e state_i
);

    import scan_pkg::*;

    int fail_count = 0;

    //////////////////////////////////////////////////
    // reset values and single-cycle pulses

    a_reset_values: assert property (@(posedge clk_i)
        scan_soft_reset_i |=> (state_i == st_idle) && (error_code_i == err_none)
                              && !scan_active_i && !shutter_en_i && !shutter_set_i
                              && !finish_i && !error_i)
        else begin
            $error("outputs not at reset values after reset");
            fail_count++;
        end

    a_pulses_short: assert property (@(posedge clk_i) disable iff (scan_soft_reset_i)
        (shutter_en_i || fbc_close_loop_i || fbc_open_loop_i || finish_i)
        |=> !(shutter_en_i || fbc_close_loop_i || fbc_open_loop_i || finish_i))
        else begin
            $error("strobe or pulse longer than one cycle");
            fail_count++;
        end

    //////////////////////////////////////////////////
    // error and scan outputs

    // error pulse carries the close strobe and a real code
    a_error_close: assert property (@(posedge clk_i) disable iff (scan_soft_reset_i)
        error_i |-> shutter_en_i && shutter_set_i && (error_code_i != err_none))
        else begin
            $error("error pulse without close strobe or code");
            fail_count++;
        end

    a_error_sticky: assert property (@(posedge clk_i) disable iff (scan_soft_reset_i)
        (state_i == st_error) |=> (state_i == st_error))
        else begin
            $error("error state left without reset");
            fail_count++;
        end

    a_active_in_scan: assert property (@(posedge clk_i) disable iff (scan_soft_reset_i)
        scan_active_i |-> (state_i == st_scan))
        else begin
            $error("scan active outside the scan state");
            fail_count++;
        end

    a_plc_in_scan: assert property (@(posedge clk_i) disable iff (scan_soft_reset_i)
        plc_acc_i |-> $past((state_i == st_scan) && plc_enable_i))
        else begin
            $error("plc acceleration outside an enabled scan");
            fail_count++;
        end

endmodule

bind scan_ctrl_top scan_ctrl_properties i_props (
    .clk_i             (clk_i),
    .scan_soft_reset_i (scan_soft_reset_i),
    .plc_enable_i      (plc_enable_i),
    .shutter_set_i     (shutter_set_o),
    .shutter_en_i      (shutter_en_o),
    .fbc_close_loop_i  (fbc_close_loop_o),
    .fbc_open_loop_i   (fbc_open_loop_o),
    .scan_active_i     (scan_active_o),
    .plc_acc_i         (plc_acc_o),
    .error_i           (error_o),
    .error_code_i      (error_code_o),
    .finish_i          (finish_o),
    .state_i           (state_o)
);

//--- verif/scan_ctrl_tb.sv
`timescale 1ns/1ns
`include "scan_config.svh"

module scan_ctrl_tb;

    import scan_pkg::*;

    localparam int RESEND_GAP = `SCAN_RESEND_CYCLES + 1;

    logic               clk_i             = 1'b0;
    logic               scan_soft_reset_i = 1'b1;
    logic               scan_start_cmd_i  = 1'b0;
    logic [31:0]        encode_i          = '0;
    encode_thresholds_t thresholds_i      = '0;
    plant_status_t      status_i          = '{shutter_closed: 1'b1, default: 1'b0};
    logic               fbc_switch_i      = 1'b0;
    logic               plc_enable_i      = 1'b0;
    logic               finish_ack_i      = 1'b0;
    logic               shutter_set_o;
    logic               shutter_en_o;
    logic               fbc_close_loop_o;
    logic               fbc_open_loop_o;
    logic               scan_active_o;
    logic               plc_acc_o;
    logic               error_o;
    scan_error_e        error_code_o;
    logic               finish_o;
    scan_state_e        state_o;

    // plant model state
    integer seed          = 76263;
    logic   ramp_on       = 1'b0;
    logic   shutter_stuck = 1'b0;
    logic   auto_ack      = 1'b0;
    logic   shutter_goal  = 1'b1;
    logic   fbc_goal      = 1'b0;
    int     shutter_dly   = 0;
    int     fbc_dly       = 0;
    logic   plc_expect    = 1'b0;

    // event counts and first or last cycle stamps
    int errors        = 0;
    int timeouts      = 0;
    int cyc           = 0;
    int n_open        = 0;
    int n_close       = 0;
    int n_fbc_close   = 0;
    int n_fbc_open    = 0;
    int n_error       = 0;
    int n_finish      = 0;
    int n_plc         = 0;
    int open_cyc      = 0;
    int active_cyc    = 0;
    int close_cyc     = 0;
    int fbc_close_cyc = 0;
    int fbc_open_cyc  = 0;
    int error_cyc     = 0;
    int finish_cyc    = 0;

    always #50 clk_i = ~clk_i;

    scan_ctrl_top i_dut (.*);

    task automatic flag_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic verify(input logic cond, input string msg);
        assert (cond) else flag_mismatch(msg);
    endtask

    //////////////////////////////////////////////////
    // monitor and plant, both on the falling edge

    always @(negedge clk_i) begin
        cyc++;
        if (!scan_soft_reset_i) begin
            assert (plc_acc_o == plc_expect) else flag_mismatch("plc_acc_o differs from model");
        end
        if (shutter_en_o && !shutter_set_o) begin
            n_open++;
            open_cyc = cyc;
        end
        if (shutter_en_o && shutter_set_o) begin
            n_close++;
            close_cyc = cyc;
            assert (!status_i.fbc_locked) else flag_mismatch("close strobe with fbc still locked");
            if (!error_o) begin
                assert (encode_i >= thresholds_i.end_pos)
                    else flag_mismatch("close strobe before end position");
            end
        end
        if (fbc_close_loop_o) begin
            n_fbc_close++;
            fbc_close_cyc = cyc;
        end
        if (fbc_open_loop_o) begin
            n_fbc_open++;
            fbc_open_cyc = cyc;
            assert (encode_i >= thresholds_i.end_pos)
                else flag_mismatch("fbc open pulse before end position");
        end
        if (scan_active_o && active_cyc == 0) begin
            active_cyc = cyc;
            assert (encode_i >= thresholds_i.start_pos)
                else flag_mismatch("scan_active_o before start position");
        end
        if (error_o) begin
            n_error++;
            error_cyc = cyc;
            assert (shutter_en_o && shutter_set_o)
                else flag_mismatch("no close strobe with the error pulse");
        end
        if (finish_o) begin
            n_finish++;
            if (n_finish > 1) begin
                assert (cyc - finish_cyc == RESEND_GAP)
                    else flag_mismatch("finish resend spacing wrong");
            end
            finish_cyc = cyc;
        end
        if (plc_acc_o) begin
            n_plc++;
        end

        // plc_acc_o shows this sample one cycle later
        plc_expect = !scan_soft_reset_i && (state_o == st_scan) && plc_enable_i
                     && (encode_i >= thresholds_i.plc_pos);

        finish_ack_i = auto_ack && finish_o;
        if (scan_soft_reset_i) begin
            encode_i    = '0;
            status_i    = '{shutter_closed: 1'b1, default: 1'b0};
            shutter_dly = 0;
            fbc_dly     = 0;
        end else begin
            if (ramp_on) begin
                encode_i = encode_i + 32'(($random(seed) & 3) + 1);
            end
            // shutter follows its strobe after 3 cycles, unless stuck closed
            if (shutter_en_o && (shutter_set_o || !shutter_stuck)) begin
                shutter_goal = shutter_set_o;
                shutter_dly  = 3;
            end else if (shutter_dly > 0) begin
                shutter_dly--;
                if (shutter_dly == 0) begin
                    status_i.shutter_closed = shutter_goal;
                end
            end
            // fbc loop locks or unlocks 4 cycles after its pulse
            if (fbc_close_loop_o || fbc_open_loop_o) begin
                fbc_goal = fbc_close_loop_o;
                fbc_dly  = 4;
            end else if (fbc_dly > 0) begin
                fbc_dly--;
                if (fbc_dly == 0) begin
                    status_i.fbc_locked = fbc_goal;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // sequence helpers

    task automatic prepare_run(input encode_thresholds_t thr, input logic fbc,
                               input logic plc_en, input logic stuck, input logic ack);
        @(negedge clk_i);
        scan_soft_reset_i = 1'b1;
        thresholds_i      = thr;
        fbc_switch_i      = fbc;
        plc_enable_i      = plc_en;
        shutter_stuck     = stuck;
        auto_ack          = ack;
        ramp_on           = 1'b0;
        repeat (5) @(negedge clk_i);
        n_open        = 0;
        n_close       = 0;
        n_fbc_close   = 0;
        n_fbc_open    = 0;
        n_error       = 0;
        n_finish      = 0;
        n_plc         = 0;
        open_cyc      = 0;
        active_cyc    = 0;
        close_cyc     = 0;
        fbc_close_cyc = 0;
        fbc_open_cyc  = 0;
        error_cyc     = 0;
        finish_cyc    = 0;
        scan_soft_reset_i = 1'b0;
        ramp_on           = 1'b1;
    endtask

    task automatic pulse_start();
        @(negedge clk_i);
        scan_start_cmd_i = 1'b1;
        @(negedge clk_i);
        scan_start_cmd_i = 1'b0;
    endtask

    task automatic reach_state(input scan_state_e target, input int limit, input string what);
        int n;
        n = 0;
        while (state_o != target && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (state_o != target) begin
            $display("timeout: controller did not reach %s within %0d cycles", what, limit);
            timeouts++;
        end
    endtask

    task automatic collect_finishes(input int count, input int limit);
        int n;
        n = 0;
        while (n_finish < count && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (n_finish < count) begin
            $display("timeout: only %0d of %0d finish pulses arrived", n_finish, count);
            timeouts++;
        end
    endtask

    task automatic quiet_cycles(input int count);
        repeat (count) @(negedge clk_i);
    endtask

    initial begin
        // plain scan, ack returned, plc enabled
        prepare_run(encode_thresholds_t'{32'd100, 32'd300, 32'd500, 32'd400}, 1'b0, 1'b1,
                    1'b0, 1'b1);
        pulse_start();
        reach_state(st_finish, 600, "finish of the plain scan");
        reach_state(st_idle, 10, "idle after the plain scan");
        quiet_cycles(3 * RESEND_GAP);
        verify(n_open == 1 && n_close == 1, "plain scan shutter strobe count");
        verify(open_cyc < active_cyc && active_cyc < close_cyc && close_cyc < finish_cyc,
               "plain scan event order");
        verify(n_finish == 1, "plain scan finish count with ack");
        verify(n_error == 0 && n_fbc_close == 0, "plain scan unexpected pulse");
        verify(state_o == st_idle, "plain scan not back in idle");
        verify(n_plc > 0, "plc_acc_o never high with plc enabled");

        // scan with fbc loop, plc disabled
        prepare_run(encode_thresholds_t'{32'd100, 32'd300, 32'd500, 32'd400}, 1'b1, 1'b0,
                    1'b0, 1'b1);
        pulse_start();
        reach_state(st_finish, 600, "finish of the fbc scan");
        quiet_cycles(5);
        verify(n_fbc_close == 1 && n_fbc_open == 1, "fbc pulse count");
        verify(fbc_close_cyc < active_cyc && active_cyc < fbc_open_cyc,
               "fbc pulses out of order with scan_active_o");
        verify(fbc_open_cyc < close_cyc, "close strobe before fbc open pulse");
        verify(n_error == 0 && n_finish == 1, "fbc scan error or finish count");
        verify(n_plc == 0, "plc_acc_o high with plc disabled");

        // start position below shutter position
        prepare_run(encode_thresholds_t'{32'd100, 32'd50, 32'd500, 32'd400}, 1'b0, 1'b1,
                    1'b0, 1'b1);
        pulse_start();
        reach_state(st_error, 100, "error after early spindle");
        quiet_cycles(2 * RESEND_GAP);
        verify(error_code_o == 4'd4, "early spindle error code");
        verify(n_error == 1 && error_cyc == close_cyc, "close strobe not with error pulse");
        verify(n_finish == 0 && n_open == 0, "early spindle opened shutter or finished");

        // shutter never opens
        prepare_run(encode_thresholds_t'{32'd100, 32'd5000, 32'd6000, 32'd5500}, 1'b0, 1'b1,
                    1'b1, 1'b1);
        pulse_start();
        reach_state(st_error, 300, "error after shutter timeout");
        quiet_cycles(3);
        verify(error_code_o == 4'd1, "shutter timeout error code");
        verify(n_open == 1 && n_error == 1, "shutter timeout strobe or error count");
        verify(error_cyc - open_cyc >= `SCAN_TIMEOUT_CYCLES, "shutter timeout came too early");

        // ack withheld, finish is resent
        prepare_run(encode_thresholds_t'{32'd100, 32'd300, 32'd500, 32'd400}, 1'b0, 1'b0,
                    1'b0, 1'b0);
        pulse_start();
        collect_finishes(3, 600 + 3 * RESEND_GAP);
        quiet_cycles(2 * RESEND_GAP);
        verify(n_finish == 3, "finish pulse count without ack");

        $display("closing: %0d value mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, i_dut.i_props.fail_count);
        if (errors == 0 && timeouts == 0 && i_dut.i_props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- scan_ctrl.f
+incdir+hdl
hdl/scan_pkg.sv
hdl/encoder_crossing.sv
hdl/phase_timer.sv
hdl/scan_sequencer.sv
hdl/finish_notifier.sv
hdl/scan_ctrl_top.sv
verif/scan_ctrl_properties.sv
verif/scan_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the scan controller testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

obj_dir/Vscan_ctrl_tb: scan_ctrl.f $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module scan_ctrl_tb -f scan_ctrl.f

test: obj_dir/Vscan_ctrl_tb
	./obj_dir/Vscan_ctrl_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
